/* logic/bus_defines.svh */
// sizing and address map of the console memory bus
// include wherever the RAM depth, flash latency or region bases are needed

`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// work RAM, 32-bit words
`define BUS_RAM_WORDS 4096
`define BUS_RAM_AW 12

// cycles from flash start to flash data valid, at least 2
`define BUS_FLASH_LATENCY 3

// byte address map
`define BUS_FLASH_BASE 16'h8000
`define BUS_PAD_ADDR 16'hC000

`endif

/* logic/bus_pkg.sv */
// shared types for the console memory bus
// request, decode and RAM port bundles plus the region and operation codes

`include "bus_defines.svh"

package bus_pkg;

    // which source serves a CPU request
    typedef enum logic [1:0] {
        REGION_RAM   = 2'd0,
        REGION_FLASH = 2'd1,
        REGION_PAD   = 2'd2,
        REGION_NONE  = 2'd3
    } region_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_t;

    // CPU side, byte address, zero strobe means read
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } cpu_req_t;

    // DMA side, already a word address
    typedef struct packed {
        logic [`BUS_RAM_AW-1:0] addr;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
    } dma_req_t;

    typedef struct packed {
        region_t                region;
        bus_op_t                op;
        logic [`BUS_RAM_AW-1:0] word_addr;
    } decode_t;

    typedef struct packed {
        logic                   cs;
        logic [`BUS_RAM_AW-1:0] addr;
        logic [31:0]            wdata;
        logic [3:0]             wstrb;
    } ram_port_t;

endpackage

/* logic/address_decoder.sv */
// decode stage of the CPU path
// maps the byte address and strobes of a request onto a region,
// an operation and a word address, purely combinational

`timescale 1ns/1ns
`include "bus_defines.svh"

module address_decoder (
    input  bus_pkg::cpu_req_t cpu_req,
    output bus_pkg::decode_t  dec
);
    import bus_pkg::*;

    localparam logic [15:0] RAM_LIMIT  = 16'(`BUS_RAM_WORDS * 4);
    localparam logic [15:0] FLASH_BASE = `BUS_FLASH_BASE;
    localparam logic [15:0] PAD_ADDR   = `BUS_PAD_ADDR;

    logic in_ram;
    logic in_flash;
    logic in_pad;

    assign in_ram   = cpu_req.addr < RAM_LIMIT;
    // flash runs up to the pad page
    assign in_flash = (cpu_req.addr >= FLASH_BASE) && (cpu_req.addr < PAD_ADDR);
    // pad port answers on one whole word
    assign in_pad   = cpu_req.addr[15:2] == PAD_ADDR[15:2];

    always_comb begin
        if (in_ram) begin
            dec.region = REGION_RAM;
        end else if (in_flash) begin
            dec.region = REGION_FLASH;
        end else if (in_pad) begin
            dec.region = REGION_PAD;
        end else begin
            dec.region = REGION_NONE;
        end
    end

    assign dec.op = (|cpu_req.wstrb) ? OP_WRITE : OP_READ;

    // RAM and flash bases are aligned, so the low bits index both
    assign dec.word_addr = cpu_req.addr[`BUS_RAM_AW+1:2];

endmodule

/* logic/bus_arbiter.sv */
// execute stage of the CPU path
// shares the work RAM between DMA and CPU with DMA taking priority,
// kicks off flash reads and produces the one-cycle CPU ready pulse

`timescale 1ns/1ns

module bus_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_valid,
    input  bus_pkg::cpu_req_t  cpu_req,
    input  bus_pkg::decode_t   dec,
    input  logic               dma_busy,
    input  bus_pkg::dma_req_t  dma_req,
    input  logic               flash_done,
    output bus_pkg::ram_port_t ram_port,
    output logic               flash_start,
    output logic [11:0]        flash_addr,
    output logic               cpu_ready
);
    import bus_pkg::*;

    logic accept;
    logic flash_rd;
    logic flash_pending;
    logic quick_ready;
    logic flash_ready;

    // DMA stalls the CPU for as long as it is busy
    assign accept   = cpu_valid && !dma_busy;
    assign flash_rd = (dec.region == REGION_FLASH) && (dec.op == OP_READ);

    // RAM port, DMA owns it outright while busy
    always_comb begin
        if (dma_busy) begin
            ram_port.cs    = 1'b1;
            ram_port.addr  = dma_req.addr;
            ram_port.wdata = dma_req.wdata;
            ram_port.wstrb = dma_req.wstrb;
        end else begin
            // held off in the ready cycle so a write lands only once
            ram_port.cs    = cpu_valid && (dec.region == REGION_RAM) && !cpu_ready;
            ram_port.addr  = dec.word_addr;
            ram_port.wdata = cpu_req.wdata;
            ram_port.wstrb = cpu_req.wstrb;
        end
    end

    // one start per flash read request
    assign flash_start = accept && flash_rd && !flash_pending && !cpu_ready;
    assign flash_addr  = dec.word_addr;

    // RAM, pad, unmapped and non-read flash accesses finish in one cycle
    assign quick_ready = accept && !flash_rd && !cpu_ready;

    // flash data is held by the port, so a late DMA only delays this
    assign flash_ready = flash_pending && flash_done && !dma_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_ready     <= 1'b0;
            flash_pending <= 1'b0;
        end else begin
            cpu_ready <= quick_ready || flash_ready;

            if (flash_start) begin
                flash_pending <= 1'b1;
            end else if (flash_ready) begin
                flash_pending <= 1'b0;
            end
        end
    end

endmodule

/* logic/read_data_mux.sv */
// result stage of the CPU path
// remembers the region of the accepted request and steers the matching
// source onto the CPU read data in the ready cycle

`timescale 1ns/1ns

module read_data_mux (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::decode_t dec,
    input  logic             accept,
    input  logic [31:0]      ram_rdata,
    input  logic [31:0]      flash_data,
    input  logic [1:0]       pad,
    output logic [31:0]      cpu_rdata
);
    import bus_pkg::*;

    region_t region_q;

    // select lines up with the registered RAM and flash outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            region_q <= REGION_NONE;
        end else if (accept) begin
            region_q <= dec.region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_RAM: begin
                cpu_rdata = ram_rdata;
            end
            REGION_FLASH: begin
                cpu_rdata = flash_data;
            end
            REGION_PAD: begin
                // pad pins sit in the bottom two bits
                cpu_rdata = {30'd0, pad};
            end
            default: begin
                cpu_rdata = 32'd0;
            end
        endcase
    end

endmodule

/* logic/work_ram.sv */
// work RAM shared by CPU and DMA
// single port, byte strobes on write, read data registered whenever
// the chip select is high

`timescale 1ns/1ns
`include "bus_defines.svh"

module work_ram (
    input  logic               clk,
    input  bus_pkg::ram_port_t ram_port,
    output logic [31:0]        rdata
);

    logic [31:0] mem [`BUS_RAM_WORDS];

    always_ff @(posedge clk) begin
        if (ram_port.cs) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_port.wstrb[b]) begin
                    mem[ram_port.addr][8*b +: 8] <= ram_port.wdata[8*b +: 8];
                end
            end
            // old word on a write cycle
            rdata <= mem[ram_port.addr];
        end
    end

endmodule

/* logic/flash_port.sv */
// boot flash model, read only
// a start pulse begins a read that completes a fixed number of cycles
// later; word w reads back as ~w in the high half and w in the low half

`timescale 1ns/1ns
`include "bus_defines.svh"

module flash_port (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [11:0] addr,
    output logic        done,
    output logic [31:0] data
);

    typedef enum logic [1:0] {
        FLASH_IDLE,
        FLASH_WAIT,
        FLASH_DONE
    } flash_state_t;

    localparam int CW = $clog2(`BUS_FLASH_LATENCY + 1);

    flash_state_t state;
    logic [CW-1:0] count;
    logic [11:0]   addr_q;
    logic [15:0]   word;
    logic          last;

    assign word = {4'd0, addr_q};
    // final wait cycle, done shows up on the next edge
    assign last = (state == FLASH_WAIT) && (count == CW'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FLASH_IDLE;
            count <= '0;
            done  <= 1'b0;
        end else if (start) begin
            state <= FLASH_WAIT;
            count <= CW'(`BUS_FLASH_LATENCY - 1);
            done  <= 1'b0;
        end else begin
            case (state)
                FLASH_WAIT: begin
                    if (last) begin
                        state <= FLASH_DONE;
                        done  <= 1'b1;
                    end else begin
                        count <= count - CW'(1);
                    end
                end
                // done and data stay up until the next start
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
        end
        if (last) begin
            data <= {~word, word};
        end
    end

endmodule

/* logic/console_bus_top.sv */
// top of the console memory bus
// CPU requests go decoder, arbiter, result mux; DMA shares the work RAM
// and the CPU also reaches the boot flash and the pad port

`timescale 1ns/1ns

module console_bus_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_valid,
    input  bus_pkg::cpu_req_t cpu_req,
    output logic              cpu_ready,
    output logic [31:0]       cpu_rdata,
    input  logic              dma_busy,
    input  bus_pkg::dma_req_t dma_req,
    input  logic [1:0]        pad
);
    import bus_pkg::*;

    decode_t     dec;
    ram_port_t   ram_port;
    logic [31:0] ram_rdata;
    logic        flash_start;
    logic [11:0] flash_addr;
    logic        flash_done;
    logic [31:0] flash_data;

    address_decoder i_address_decoder (
        .cpu_req (cpu_req),
        .dec     (dec)
    );

    bus_arbiter i_bus_arbiter (
        .clk         (clk),
        .rst         (rst),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .dec         (dec),
        .dma_busy    (dma_busy),
        .dma_req     (dma_req),
        .flash_done  (flash_done),
        .ram_port    (ram_port),
        .flash_start (flash_start),
        .flash_addr  (flash_addr),
        .cpu_ready   (cpu_ready)
    );

    read_data_mux i_read_data_mux (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .accept     (cpu_valid && !dma_busy),
        .ram_rdata  (ram_rdata),
        .flash_data (flash_data),
        .pad        (pad),
        .cpu_rdata  (cpu_rdata)
    );

    work_ram i_work_ram (
        .clk      (clk),
        .ram_port (ram_port),
        .rdata    (ram_rdata)
    );

    flash_port i_flash_port (
        .clk   (clk),
        .rst   (rst),
        .start (flash_start),
        .addr  (flash_addr),
        .done  (flash_done),
        .data  (flash_data)
    );

endmodule

/* test/console_bus_tb.sv */
// testbench for the console memory bus
// replays test/bus_input.txt against the top level, one transaction per line,
// and checks read data, ready latency and the single ready pulse

`timescale 1ns/1ns
`include "bus_defines.svh"

module console_bus_tb;
    import bus_pkg::*;

    logic        clk;
    logic        rst;
    logic        cpu_valid;
    cpu_req_t    cpu_req;
    logic        cpu_ready;
    logic [31:0] cpu_rdata;
    logic        dma_busy;
    dma_req_t    dma_req;
    logic [1:0]  pad;

    int mismatches;
    int failures;
    int transactions;

    console_bus_top i_console_bus_top (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .dma_busy  (dma_busy),
        .dma_req   (dma_req),
        .pad       (pad)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // inputs change 1 ns after the edge, outputs are settled by then
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
            mismatches++;
        end
    endtask

    // flash reads wait out the flash latency, everything else is one cycle
    function automatic int expected_latency(input logic [15:0] addr, input logic [3:0] strb);
        if (strb == 4'd0 && addr >= `BUS_FLASH_BASE && addr < `BUS_PAD_ADDR) begin
            return `BUS_FLASH_LATENCY + 1;
        end
        return 1;
    endfunction

    task automatic wait_ready(output int cycles, output bit seen);
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 50) begin
            step();
            cycles++;
            seen = (cpu_ready === 1'b1);
        end
    endtask

    // checks the ready cycle, then holds the request across the sampling edge
    task automatic finish_request(input bit seen, input int cycles, input int latency,
                                  input logic [3:0] strb, input logic [31:0] expected,
                                  input string name);
        if (!seen) begin
            $display("timeout: no cpu_ready within 50 cycles for %s", name);
            failures++;
        end else begin
            check_value({name, " latency"}, latency, cycles);
            if (strb == 4'd0) begin
                check_value({name, " rdata"}, expected, cpu_rdata);
            end
        end
        step();
        if (cpu_ready !== 1'b0) begin
            $display("second ready pulse while the request was still held for %s", name);
            failures++;
        end
        cpu_valid = 1'b0;
        cpu_req   = '0;
    endtask

    task automatic cpu_access(input logic [15:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, input logic [31:0] expected,
                              input string name);
        int cycles;
        bit seen;
        cpu_valid     = 1'b1;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.wstrb = strb;
        wait_ready(cycles, seen);
        finish_request(seen, cycles, expected_latency(addr, strb), strb, expected, name);
    endtask

    // DMA write with a CPU read of the same word stalled behind it
    task automatic dma_with_cpu(input logic [11:0] waddr, input logic [31:0] wdata,
                                input logic [3:0] strb, input logic [31:0] expected,
                                input string name);
        int hold;
        int cycles;
        bit seen;
        hold          = 1 + int'($urandom % 4);
        dma_busy      = 1'b1;
        dma_req.addr  = waddr;
        dma_req.wdata = wdata;
        dma_req.wstrb = strb;
        cpu_valid     = 1'b1;
        cpu_req.addr  = {2'b00, waddr, 2'b00};
        cpu_req.wdata = 32'd0;
        cpu_req.wstrb = 4'd0;
        for (int i = 0; i < hold; i++) begin
            step();
            if (cpu_ready !== 1'b0) begin
                $display("cpu_ready went high while DMA was busy for %s", name);
                failures++;
            end
        end
        dma_busy = 1'b0;
        dma_req  = '0;
        wait_ready(cycles, seen);
        finish_request(seen, cycles, 1, 4'd0, expected, name);
    endtask

    initial begin
        int fd;
        int lineno;
        int count;
        int unsigned seed;
        string line;
        string name;
        logic [23:0] cmd;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] strb;
        logic [31:0] expected;

        mismatches   = 0;
        failures     = 0;
        transactions = 0;
        rst          = 1'b1;
        cpu_valid    = 1'b0;
        cpu_req      = '0;
        dma_busy     = 1'b0;
        dma_req      = '0;
        pad          = 2'b00;
        seed         = 32'he10f_4160;
        void'($urandom(seed));

        for (int i = 0; i < 10; i++) begin
            step();
            if (cpu_ready !== 1'b0) begin
                $display("cpu_ready was not low during reset cycle %0d", i);
                failures++;
            end
        end
        rst = 1'b0;

        fd = $fopen("test/bus_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/bus_input.txt");
            failures++;
        end else begin
            lineno = 0;
            while (!$feof(fd)) begin
                line = "";
                count = $fgets(line, fd);
                lineno++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    count = $sscanf(line, "%s %h %h %h %h", cmd, addr, wdata, strb, expected);
                    name = $sformatf("line %0d %s %04h", lineno, cmd, addr[15:0]);
                    if (count != 5) begin
                        $display("line %0d of the stimulus file could not be parsed", lineno);
                        failures++;
                    end else if (cmd == "cpu") begin
                        cpu_access(addr[15:0], wdata, strb[3:0], expected, name);
                        transactions++;
                    end else if (cmd == "dma") begin
                        dma_with_cpu(addr[11:0], wdata, strb[3:0], expected, name);
                        transactions++;
                    end else if (cmd == "pad") begin
                        pad = wdata[1:0];
                    end else begin
                        $display("line %0d has an unknown command", lineno);
                        failures++;
                    end
                end
            end
            $fclose(fd);
        end

        step();
        $display("transactions %0d, mismatches %0d, other errors %0d",
                 transactions, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/bus_pkg.sv
logic/address_decoder.sv
logic/bus_arbiter.sv
logic/read_data_mux.sv
logic/work_ram.sv
logic/flash_port.sv
logic/console_bus_top.sv
test/console_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the console bus testbench with Verilator, run it and scan the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ns -f compile.f \
    --top-module console_bus_tb -o console_bus_sim

./obj_dir/console_bus_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

/* test/bus_input.txt */
# command address write_data strobe expected_read, all hex
# cpu uses a byte address, dma a RAM word address re-read by the CPU, pad drives write_data[1:0]
cpu 0010 11223344 f 00000000
cpu 0010 00000000 0 11223344
cpu 0010 aabbccdd 5 00000000
cpu 0010 00000000 0 11bb33dd
cpu 0020 cafef00d f 00000000
cpu 0020 12345678 a 00000000
cpu 0020 00000000 0 12fe560d
cpu 3ffc 89abcdef f 00000000
cpu 3ffc 00000000 0 89abcdef
cpu 8000 00000000 0 ffff0000
cpu 8004 00000000 0 fffe0001
cpu 8010 00000000 0 fffb0004
cpu 8abc 00000000 0 fd5002af
cpu bffc 00000000 0 f0000fff
pad 0000 00000002 0 00000000
cpu c000 00000000 0 00000002
pad 0000 00000003 0 00000000
cpu c000 00000000 0 00000003
cpu 4000 00000000 0 00000000
cpu 7ffc 00000000 0 00000000
cpu c004 00000000 0 00000000
cpu fffc 00000000 0 00000000
cpu 8010 ffffffff f 00000000
cpu 8020 ffffffff 3 00000000
cpu 4010 55555555 f 00000000
cpu c008 55555555 f 00000000
cpu 8010 00000000 0 fffb0004
cpu 0010 00000000 0 11bb33dd
cpu 0020 00000000 0 12fe560d
dma 010 deadbeef f deadbeef
dma 010 00000099 1 deadbe99
dma 004 77000000 8 77bb33dd
cpu 0040 00000000 0 deadbe99
cpu 0010 00000000 0 77bb33dd
cpu 8004 00000000 0 fffe0001
